/* tagged_mem.f */
design/mem_pkg.sv
design/mem_array.sv
design/tag_tracker.sv
design/latency_timer.sv
design/load_buffer.sv
design/tagged_mem.sv
verification/tagged_mem_chk.sv
verification/tagged_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the tagged_mem testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tagged_mem_tb \
    -Mdir obj_dir \
    -f tagged_mem.f

./obj_dir/Vtagged_mem_tb | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"

/* verification/tagged_mem_tb.sv */
module tagged_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    localparam int directed_requests  = 64;
    localparam int random_requests    = 300;
    localparam int cycles_per_request = mem_latency + num_tags + 4;

    logic         clock;
    logic         arst_n;
    mem_command_t command;
    addr_t        addr;
    mem_size_t    size;
    mem_block_t   data;
    tag_t         transaction_tag;
    mem_block_t   load_data;
    tag_t         data_tag;

    int seed;
    int check_errors    = 0;
    int protocol_errors = 0;
    int issued          = 0;
    int loads_granted   = 0;
    int loads_returned  = 0;

    // Reference model
    logic [7:0]  ref_mem [mem_size_bytes];
    tag_state_t  ref_state [1:num_tags];
    int          ref_remain [1:num_tags];    // Edges left until the timer expires
    logic        ref_is_load [1:num_tags];
    mem_block_t  ref_slot [1:num_tags];      // Expected data per granted load tag
    tag_t        exp_ttag = '0;
    tag_t        exp_dtag = '0;
    mem_block_t  exp_data = '0;

    tagged_mem dut_i (
        .clock           (clock),
        .arst_n          (arst_n),
        .command         (command),
        .addr            (addr),
        .size            (size),
        .data            (data),
        .transaction_tag (transaction_tag),
        .load_data       (load_data),
        .data_tag        (data_tag)
    );

    bind tag_tracker tagged_mem_chk chk_i (
        .clock           (clock),
        .arst_n          (arst_n),
        .state           (state),
        .transaction_tag (transaction_tag),
        .data_tag        (data_tag)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////
    // Reference rules
    ////////////////////

    function automatic logic addr_valid(input addr_t a, input mem_size_t s);
        int width;
        width = 1 << int'(s);
        return (int'(a) < mem_size_bytes) && ((int'(a) % width) == 0);   // Range and natural alignment
    endfunction

    // Zero-extended value of the addressed field
    function automatic mem_block_t expected_load(input addr_t a, input mem_size_t s);
        mem_block_t value;
        int         width;
        value = '0;
        width = 1 << int'(s);
        for (int i = 0; i < width; i++) begin
            value[8*i +: 8] = ref_mem[int'(a) + i];
        end
        return value;
    endfunction

    task automatic apply_store(input addr_t a, input mem_size_t s, input mem_block_t d);
        int width;
        width = 1 << int'(s);
        for (int i = 0; i < width; i++) begin
            ref_mem[int'(a) + i] = d[8*i +: 8];   // Little-endian within the line
        end
    endtask

    function automatic logic model_idle();
        for (int t = 1; t <= num_tags; t++) begin
            if (ref_state[t] != tag_free) return 1'b0;
        end
        return 1'b1;
    endfunction

    // One step per rising edge using the state before the edge
    always @(posedge clock) begin : reference_step
        tag_t ret;
        tag_t alloc;
        ret   = '0;
        alloc = '0;
        if (!arst_n) begin
            for (int i = 0; i < mem_size_bytes; i++) ref_mem[i] = '0;
            for (int t = 1; t <= num_tags; t++) begin
                ref_state[t]  = tag_free;
                ref_remain[t] = 0;
            end
            exp_ttag = '0;
            exp_dtag = '0;
            exp_data = '0;
        end else begin
            for (int t = num_tags; t >= 1; t--) begin
                if (ref_state[t] == tag_wait_bus) ret = tag_t'(t);   // Lowest ready tag wins
            end
            if ((command != mem_none) && addr_valid(addr, size)) begin
                for (int t = num_tags; t >= 1; t--) begin
                    if (ref_state[t] == tag_free) alloc = tag_t'(t);
                end
            end
            exp_dtag = ret;
            exp_data = (ret != '0) ? ref_slot[ret] : '0;
            if (ret != '0) ref_state[ret] = tag_free;
            for (int t = 1; t <= num_tags; t++) begin
                if (ref_state[t] == tag_busy) begin
                    ref_remain[t]--;
                    if (ref_remain[t] == 0) begin
                        if (ref_is_load[t]) ref_state[t] = tag_wait_bus;
                        else ref_state[t] = tag_free;
                    end
                end
            end
            exp_ttag = alloc;
            if (alloc != '0) begin
                ref_state[alloc]   = tag_busy;
                ref_remain[alloc]  = mem_latency;
                ref_is_load[alloc] = (command == mem_load);
                if (command == mem_load) begin
                    ref_slot[alloc] = expected_load(addr, size);   // Data fixed at acceptance
                    loads_granted++;
                end else begin
                    apply_store(addr, size, data);
                end
            end
        end
    end

    ////////////////////
    // Compare
    ////////////////////

    task automatic check_tag(input tag_t got, input tag_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_block(input mem_block_t got, input mem_block_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            check_errors++;
        end
    endtask

    // Outputs are stable half a cycle after the edge
    always @(negedge clock) begin
        check_tag(transaction_tag, exp_ttag, "transaction_tag");
        check_tag(data_tag, exp_dtag, "data_tag");
        check_block(load_data, exp_data, "load_data");
        if (data_tag != '0) loads_returned++;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic mem_block_t random_block();
        return {$random(seed), $random(seed)};
    endfunction

    // Called 10 ns after a rising edge, returns at the same point one cycle later
    task automatic send(input mem_command_t c, input addr_t a, input mem_size_t s,
                        input mem_block_t d, output tag_t t);
        command = c;
        addr    = a;
        size    = s;
        data    = d;
        if (c != mem_none) issued++;
        @(posedge clock);
        #10;
        command = mem_none;
        t       = transaction_tag;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #10;
        end
    endtask

    task automatic wait_return(input tag_t t);
        int waited;
        waited = 0;
        while ((data_tag !== t) && (waited < cycles_per_request * num_tags)) begin
            idle(1);
            waited++;
        end
        if (data_tag !== t) begin
            $display("Load on tag %0d never returned its data", t);
            protocol_errors++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (!model_idle() && (waited < cycles_per_request * num_tags)) begin
            idle(1);
            waited++;
        end
        if (!model_idle()) begin
            $display("Outstanding operations did not complete in time");
            protocol_errors++;
        end
    endtask

    task automatic merge_sizes();
        tag_t  t;
        int    width;
        addr_t base;
        for (int s = 0; s < 4; s++) begin
            width = 1 << s;
            base  = addr_t'(64 + 8 * s);
            send(mem_store, base, size_double, 64'hfedc_ba98_7654_3210, t);
            for (int off = 0; off < 8; off += width) begin
                send(mem_store, base + addr_t'(off), mem_size_t'(s), random_block(), t);
                send(mem_load, base + addr_t'(off), mem_size_t'(s), '0, t);
                wait_return(t);
            end
            send(mem_load, base, size_double, '0, t);   // Whole line shows every merged field
            wait_return(t);
        end
    endtask

    task automatic fill_tags();
        tag_t got [8];
        drain();
        for (int i = 0; i < 8; i++) send(mem_load, addr_t'(8 * i), size_double, '0, got[i]);
        for (int i = 0; i < 7; i++) check_tag(got[i], tag_t'(i + 1), "back-to-back load tag");
        check_tag(got[7], '0, "eighth load with all tags busy");
        wait_return(tag_t'(1));
        send(mem_load, addr_t'(56), size_double, '0, got[7]);
        check_tag(got[7], tag_t'(1), "retried load tag");
        drain();
    endtask

    task automatic refuse_bad_addresses();
        tag_t t;
        send(mem_store, 9'h041, size_half, '1, t);
        check_tag(t, '0, "misaligned half store");
        send(mem_store, 9'h042, size_word, '1, t);
        check_tag(t, '0, "misaligned word store");
        send(mem_store, 9'h044, size_double, '1, t);
        check_tag(t, '0, "misaligned double store");
        send(mem_load, 9'h0a3, size_word, '0, t);
        check_tag(t, '0, "misaligned word load");
        // A 9-bit address never exceeds the bound, so the top byte is legal
        send(mem_load, 9'h1ff, size_byte, '0, t);
        wait_return(t);
        send(mem_load, 9'h040, size_double, '0, t);
        wait_return(t);
    endtask

    task automatic order_load_store();
        tag_t t;
        tag_t t_old;
        tag_t t_new;
        send(mem_store, 9'h100, size_word, 64'h0000_0000_1234_5678, t);
        send(mem_load, 9'h100, size_word, '0, t_old);
        send(mem_store, 9'h100, size_word, 64'h0000_0000_cafe_f00d, t);
        send(mem_load, 9'h100, size_word, '0, t_new);
        wait_return(t_old);
        wait_return(t_new);
    endtask

    task automatic order_returns();
        tag_t got [num_tags];
        drain();
        for (int i = 0; i < num_tags; i++) begin
            send(mem_load, addr_t'(64 + 8 * i), size_double, '0, got[i]);
        end
        for (int i = 0; i < num_tags; i++) begin
            check_tag(got[i], tag_t'(i + 1), "concurrent load tag");
            wait_return(got[i]);   // Lowest tag must come back first
        end
    endtask

    task automatic random_mix();
        logic [31:0]  r;
        mem_command_t c;
        mem_size_t    s;
        addr_t        a;
        tag_t         t;
        for (int n = 0; n < random_requests; n++) begin
            r = $random(seed);
            c = (r[1:0] == 2'd0) ? mem_none : (r[2] ? mem_load : mem_store);
            s = mem_size_t'(r[4:3]);
            a = addr_t'($random(seed));
            if (r[7:5] != 3'd0) a = a & ~addr_t'((1 << int'(s)) - 1);   // Mostly aligned
            send(c, a, s, random_block(), t);
        end
    endtask

    initial begin
        seed    = 32'h9c8b_900a;
        command = mem_none;
        addr    = '0;
        size    = size_byte;
        data    = '0;
        arst_n  = 1'b0;
        repeat (16) @(posedge clock);
        #10;
        arst_n = 1'b1;
        check_tag(transaction_tag, '0, "transaction_tag after reset");
        check_tag(data_tag, '0, "data_tag after reset");
        check_block(load_data, '0, "load_data after reset");
        merge_sizes();
        fill_tags();
        refuse_bad_addresses();
        order_load_store();
        order_returns();
        random_mix();
        drain();
        idle(2);
        if (loads_returned != loads_granted) begin
            $display("Loads granted %0d but %0d returned", loads_granted, loads_returned);
            protocol_errors++;
        end
        $display("Errors: %0d data checks, %0d protocol", check_errors, protocol_errors);
        if ((check_errors + protocol_errors) == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (16 + (directed_requests + random_requests) * cycles_per_request) begin
            @(posedge clock);
        end
        $display("Watchdog expired after %0d requests, simulation stopped", issued);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* verification/tagged_mem_chk.sv */
module tagged_mem_chk (
    input logic                clock,
    input logic                arst_n,
    input mem_pkg::tag_state_t state [1:mem_pkg::num_tags],
    input mem_pkg::tag_t       transaction_tag,
    input mem_pkg::tag_t       data_tag
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    logic [num_tags:0] was_free;      // Tag states one edge back, bit 0 unused
    logic [num_tags:0] was_waiting;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            was_free    <= {{num_tags{1'b1}}, 1'b0};
            was_waiting <= '0;
        end else begin
            was_free[0]    <= 1'b0;
            was_waiting[0] <= 1'b0;
            for (int i = 1; i <= num_tags; i++) begin
                was_free[i]    <= (state[i] == tag_free);
                was_waiting[i] <= (state[i] == tag_wait_bus);
            end
        end
    end

    ////////////////////
    // Tag protocol
    ////////////////////

    a_grant_free: assert property (@(posedge clock) disable iff (!arst_n)
        (transaction_tag != '0) |-> was_free[transaction_tag])
        else $error("transaction_tag %0d named a tag that was in use", transaction_tag);

    a_return_waiting: assert property (@(posedge clock) disable iff (!arst_n)
        (data_tag != '0) |-> was_waiting[data_tag])
        else $error("data_tag %0d named a tag that was not waiting for the bus", data_tag);

    // Tag outputs stay quiet while reset is held
    a_reset_quiet: assert property (@(posedge clock)
        !arst_n |-> ((transaction_tag == '0) && (data_tag == '0)))
        else $error("Tag outputs not zero during reset");

endmodule

/* design/tagged_mem.sv */
module tagged_mem (
    input  logic                  clock,
    input  logic                  arst_n,
    input  mem_pkg::mem_command_t command,
    input  mem_pkg::addr_t        addr,
    input  mem_pkg::mem_size_t    size,
    input  mem_pkg::mem_block_t   data,
    output mem_pkg::tag_t         transaction_tag,
    output mem_pkg::mem_block_t   load_data,
    output mem_pkg::tag_t         data_tag
);
    import mem_pkg::*;

    logic              address_ok;
    mem_block_t        read_block;
    logic              grant;
    tag_t              grant_tag;
    logic              grant_is_load;
    logic              return_valid;
    tag_t              return_tag;
    logic [num_tags:1] expired;

    ////////////////////
    // Storage
    ////////////////////

    mem_array u_mem_array (
        .clock      (clock),
        .arst_n     (arst_n),
        .command    (command),
        .addr       (addr),
        .size       (size),
        .data       (data),
        .grant      (grant),
        .address_ok (address_ok),
        .read_block (read_block)
    );

    ////////////////////
    // Tag control
    ////////////////////

    tag_tracker u_tag_tracker (
        .clock           (clock),
        .arst_n          (arst_n),
        .command         (command),
        .address_ok      (address_ok),
        .expired         (expired),
        .grant           (grant),
        .grant_tag       (grant_tag),
        .grant_is_load   (grant_is_load),
        .return_valid    (return_valid),
        .return_tag      (return_tag),
        .transaction_tag (transaction_tag),
        .data_tag        (data_tag)
    );

    latency_timer u_latency_timer (
        .clock     (clock),
        .arst_n    (arst_n),
        .grant     (grant),
        .grant_tag (grant_tag),
        .expired   (expired)
    );

    load_buffer u_load_buffer (
        .clock         (clock),
        .arst_n        (arst_n),
        .grant_is_load (grant_is_load),
        .grant_tag     (grant_tag),
        .read_block    (read_block),
        .return_valid  (return_valid),
        .return_tag    (return_tag),
        .load_data     (load_data)
    );

endmodule

/* design/load_buffer.sv */
module load_buffer (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                grant_is_load,
    input  mem_pkg::tag_t       grant_tag,
    input  mem_pkg::mem_block_t read_block,
    input  logic                return_valid,
    input  mem_pkg::tag_t       return_tag,
    output mem_pkg::mem_block_t load_data
);
    import mem_pkg::*;

    mem_block_t slot [1:num_tags];   // Load data held until its return

    // Data is taken at acceptance, so later stores do not affect it
    always_ff @(posedge clock) begin
        if (grant_is_load) begin
            slot[grant_tag] <= read_block;
        end
    end

    ////////////////////
    // Return data
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            load_data <= '0;
        end else if (return_valid) begin
            load_data <= slot[return_tag];
        end else begin
            load_data <= '0;   // Bus idle
        end
    end

endmodule

/* design/latency_timer.sv */
module latency_timer (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       grant,
    input  mem_pkg::tag_t              grant_tag,
    output logic [mem_pkg::num_tags:1] expired
);
    import mem_pkg::*;

    logic [count_width-1:0] count [1:num_tags];
    logic [num_tags:1]      started;   // Counter has been loaded at least once

    ////////////////////
    // Countdown per tag
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            started <= '0;
            for (int i = 1; i <= num_tags; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 1; i <= num_tags; i++) begin
                if (grant && (grant_tag == tag_t'(i))) begin
                    // The request cycle is the first cycle of the latency
                    count[i]   <= count_width'(mem_latency - 1);
                    started[i] <= 1'b1;
                end else if (count[i] != '0) begin
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

    // Stays high until the tag is granted again
    always_comb begin
        for (int i = 1; i <= num_tags; i++) begin
            expired[i] = started[i] && (count[i] == '0);
        end
    end

endmodule

/* design/tag_tracker.sv */
module tag_tracker (
    input  logic                       clock,
    input  logic                       arst_n,
    input  mem_pkg::mem_command_t      command,
    input  logic                       address_ok,
    input  logic [mem_pkg::num_tags:1] expired,
    output logic                       grant,
    output mem_pkg::tag_t              grant_tag,
    output logic                       grant_is_load,
    output logic                       return_valid,
    output mem_pkg::tag_t              return_tag,
    output mem_pkg::tag_t              transaction_tag,
    output mem_pkg::tag_t              data_tag
);
    import mem_pkg::*;

    tag_state_t        state [1:num_tags];
    logic [num_tags:1] load_op;     // Tag was granted to a load
    tag_t              free_tag;    // Lowest free tag, 0 when all are in use
    logic              request;

    ////////////////////
    // Allocation
    ////////////////////

    assign request = (command == mem_load) || (command == mem_store);

    always_comb begin
        free_tag = '0;
        for (int i = num_tags; i >= 1; i--) begin
            if (state[i] == tag_free) begin
                free_tag = tag_t'(i);
            end
        end
    end

    assign grant         = request && address_ok && (free_tag != '0);
    assign grant_tag     = grant ? free_tag : '0;
    assign grant_is_load = grant && (command == mem_load);

    ////////////////////
    // Return bus
    ////////////////////

    // One load per cycle, lowest ready tag wins
    always_comb begin
        return_tag = '0;
        for (int i = num_tags; i >= 1; i--) begin
            if ((state[i] == tag_wait_bus) && expired[i]) begin
                return_tag = tag_t'(i);
            end
        end
    end

    assign return_valid = (return_tag != '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            transaction_tag <= '0;
            data_tag        <= '0;
            load_op         <= '0;
            for (int i = 1; i <= num_tags; i++) begin
                state[i] <= tag_free;
            end
        end else begin
            transaction_tag <= grant_tag;    // 0 on refusal or idle
            data_tag        <= return_tag;   // Same edge as load_data
            for (int i = 1; i <= num_tags; i++) begin
                case (state[i])
                    tag_free: begin
                        if (grant_tag == tag_t'(i)) begin
                            state[i]   <= tag_busy;
                            load_op[i] <= grant_is_load;
                        end
                    end
                    tag_busy: begin
                        if (expired[i]) begin
                            // Stores are done here, loads still need the bus
                            state[i] <= load_op[i] ? tag_wait_bus : tag_free;
                        end
                    end
                    tag_wait_bus: begin
                        if (return_tag == tag_t'(i)) begin
                            state[i] <= tag_free;
                        end
                    end
                    default: state[i] <= tag_free;
                endcase
            end
        end
    end

endmodule

/* design/mem_array.sv */
module mem_array (
    input  logic                  clock,
    input  logic                  arst_n,
    input  mem_pkg::mem_command_t command,
    input  mem_pkg::addr_t        addr,
    input  mem_pkg::mem_size_t    size,
    input  mem_pkg::mem_block_t   data,
    input  logic                  grant,
    output logic                  address_ok,
    output mem_pkg::mem_block_t   read_block
);
    import mem_pkg::*;

    mem_block_t mem [mem_lines];

    logic [addr_width-4:0] line_idx;    // Selects the 64-bit line
    logic [2:0]            byte_off;    // Byte within the line
    logic [5:0]            shift;       // Bit offset of the field
    mem_block_t            line;
    mem_block_t            field_mask;
    mem_block_t            merged;
    logic                  aligned;

    assign line_idx = addr[addr_width-1:3];
    assign byte_off = addr[2:0];
    assign shift    = {byte_off, 3'b000};
    assign line     = mem[line_idx];

    ////////////////////
    // Address checks
    ////////////////////

    always_comb begin
        case (size)
            size_byte:   aligned = 1'b1;
            size_half:   aligned = (byte_off[0] == 1'b0);
            size_word:   aligned = (byte_off[1:0] == 2'b00);
            default:     aligned = (byte_off == 3'b000);   // Double
        endcase
        address_ok = aligned;   // Any addr_width-bit address lies inside the array
    end

    // Width of the accessed field, right-justified
    always_comb begin
        case (size)
            size_byte:   field_mask = 64'h0000_0000_0000_00ff;
            size_half:   field_mask = 64'h0000_0000_0000_ffff;
            size_word:   field_mask = 64'h0000_0000_ffff_ffff;
            default:     field_mask = '1;
        endcase
    end

    ////////////////////
    // Data paths
    ////////////////////

    // Loads see the field shifted down with upper bits zero
    assign read_block = (line >> shift) & field_mask;

    // Store field replaces only its own bytes of the line
    assign merged = (line & ~(field_mask << shift)) | ((data & field_mask) << shift);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < mem_lines; i++) begin
                mem[i] <= '0;
            end
        end else if (grant && (command == mem_store)) begin
            mem[line_idx] <= merged;   // Visible to a load in the next cycle
        end
    end

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

    ////////////////////
    // Memory geometry
    ////////////////////

    localparam int mem_lines      = 64;              // 64-bit lines
    localparam int mem_size_bytes = mem_lines * 8;   // Address bound
    localparam int addr_width     = 9;

    ////////////////////
    // Tags and timing
    ////////////////////

    localparam int num_tags    = 7;                  // Tags 1..7, 0 is reserved
    localparam int mem_latency = 8;                  // Cycles until a tag's timer expires
    localparam int count_width = $clog2(mem_latency + 1);

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [2:0]            tag_t;            // 0 means none or refused
    typedef logic [63:0]           mem_block_t;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_command_t;

    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } mem_size_t;

    // Life cycle of one tag
    typedef enum logic [1:0] {
        tag_free     = 2'd0,
        tag_busy     = 2'd1,                         // Timer running
        tag_wait_bus = 2'd2                          // Load done, waiting for the return bus
    } tag_state_t;

endpackage
